// ==== include/vfdsu_macros.svh ====
/*
 * widths, format codes, field positions, exponent biases
 * and rounding-mode codes for the divide/sqrt operand prepare stage
 */
`ifndef VFDSU_MACROS_SVH
`define VFDSU_MACROS_SVH

`define VFDSU_SRC_W       64
`define VFDSU_FRAC_W      52
`define VFDSU_SRT_W       53
`define VFDSU_REM_W       60
`define VFDSU_EXP_W       13

// format codes
`define VFDSU_FMT_DOUBLE  2'd0
`define VFDSU_FMT_SINGLE  2'd1
`define VFDSU_FMT_HALF    2'd2

// sign bit, exponent lsb and exponent width per format
`define VFDSU_DBL_SIGN    63
`define VFDSU_DBL_EXP_LSB 52
`define VFDSU_DBL_EXP_W   11
`define VFDSU_SGL_SIGN    31
`define VFDSU_SGL_EXP_LSB 23
`define VFDSU_SGL_EXP_W   8
`define VFDSU_HLF_SIGN    15
`define VFDSU_HLF_EXP_LSB 10
`define VFDSU_HLF_EXP_W   5

`define VFDSU_BIAS_DOUBLE 13'd1023
`define VFDSU_BIAS_SINGLE 13'd127
`define VFDSU_BIAS_HALF   13'd15

// rounding modes
`define VFDSU_RM_RNE      3'd0
`define VFDSU_RM_RTZ      3'd1
`define VFDSU_RM_RDN      3'd2
`define VFDSU_RM_RUP      3'd3
`define VFDSU_RM_RMM      3'd4
`define VFDSU_RM_DYN      3'd7

`endif

// ==== logic/vfdsu_operand_unpack.sv ====
/*
 * operand unpack: field select per format, fraction alignment,
 * class decode and leading-zero normalisation of subnormals
 */
`default_nettype none

`include "vfdsu_macros.svh"

module vfdsu_operand_unpack
  import vfdsu_pkg::*;
(
  input  fp_src_t     src,
  input  fp_fmt_t     fmt,
  output opnd_class_t cls
);

  logic      sign;
  logic      exp_zero;
  logic      exp_max;
  fp_expnt_t exp_field;
  fp_frac_t  frac;
  fp_frac_t  frac_shl;
  logic      frac_zero;
  logic      is_denorm;
  logic [5:0] lzc;

  // pick fields, fraction left aligned to bit 51
  always_comb
  begin
    case (fmt)
      `VFDSU_FMT_DOUBLE:
      begin
        sign      = src[`VFDSU_DBL_SIGN];
        exp_field = {2'b0, src[`VFDSU_DBL_SIGN-1 -: `VFDSU_DBL_EXP_W]};
        exp_max   = &src[`VFDSU_DBL_SIGN-1 -: `VFDSU_DBL_EXP_W];
        frac      = src[`VFDSU_DBL_EXP_LSB-1:0];
      end
      `VFDSU_FMT_SINGLE:
      begin
        sign      = src[`VFDSU_SGL_SIGN];
        exp_field = {5'b0, src[`VFDSU_SGL_SIGN-1 -: `VFDSU_SGL_EXP_W]};
        exp_max   = &src[`VFDSU_SGL_SIGN-1 -: `VFDSU_SGL_EXP_W];
        frac      = {src[`VFDSU_SGL_EXP_LSB-1:0],
                     {(`VFDSU_FRAC_W-`VFDSU_SGL_EXP_LSB){1'b0}}};
      end
      // half, and the unused code
      default:
      begin
        sign      = src[`VFDSU_HLF_SIGN];
        exp_field = {8'b0, src[`VFDSU_HLF_SIGN-1 -: `VFDSU_HLF_EXP_W]};
        exp_max   = &src[`VFDSU_HLF_SIGN-1 -: `VFDSU_HLF_EXP_W];
        frac      = {src[`VFDSU_HLF_EXP_LSB-1:0],
                     {(`VFDSU_FRAC_W-`VFDSU_HLF_EXP_LSB){1'b0}}};
      end
    endcase
  end

  assign exp_zero  = (exp_field == '0);
  assign frac_zero = ~|frac;
  assign is_denorm = exp_zero & ~frac_zero;

  // leading zeros of the aligned fraction, highest set bit wins
  always_comb
  begin
    lzc = '0;
    for (int i = 0; i < `VFDSU_FRAC_W; i++)
    begin
      if (frac[i])
      begin
        lzc = 6'(`VFDSU_FRAC_W - 1 - i);
      end
    end
  end

  assign frac_shl = frac << lzc;

  always_comb
  begin
    cls.sign    = sign;
    cls.zero    = exp_zero & frac_zero;
    cls.inf     = exp_max & frac_zero;
    cls.snan    = exp_max & ~frac_zero & ~frac[`VFDSU_FRAC_W-1];
    cls.qnan    = exp_max & frac[`VFDSU_FRAC_W-1];
    cls.denorm  = is_denorm;
    cls.norm    = (~exp_zero & ~exp_max) | is_denorm;
    cls.payload = frac;
    if (is_denorm)
    begin
      // subnormal: exponent -L, hidden one moved up to the top
      cls.expnt = '0 - fp_expnt_t'(lzc);
      cls.srt   = {frac_shl, 1'b0};
    end
    else
    begin
      cls.expnt = exp_field;
      cls.srt   = {1'b1, frac};
    end
  end

endmodule

`default_nettype wire

// ==== logic/vfdsu_pkg.sv ====
/*
 * vector types and packed bundles of the divide/sqrt prepare stage:
 * request, operand class, special result and the ex2 register
 */
`default_nettype none

`include "vfdsu_macros.svh"

package vfdsu_pkg;

  typedef logic [`VFDSU_SRC_W-1:0]  fp_src_t;
  typedef logic [1:0]               fp_fmt_t;
  typedef logic [`VFDSU_FRAC_W-1:0] fp_frac_t;
  typedef logic [`VFDSU_SRT_W-1:0]  srt_opnd_t;
  typedef logic [`VFDSU_REM_W-1:0]  srt_rem_t;
  // two's complement
  typedef logic [`VFDSU_EXP_W-1:0]  fp_expnt_t;
  typedef logic [2:0]               fp_rm_t;

  // op_sqrt set selects square root, clear selects divide
  typedef struct packed {
    logic    op_sqrt;
    fp_fmt_t fmt;
    fp_src_t src0;
    fp_src_t src1;
  } vfdsu_req_t;

  typedef struct packed {
    logic      sign;
    logic      zero;
    logic      inf;
    logic      snan;
    logic      qnan;
    logic      denorm;
    logic      norm;
    fp_expnt_t expnt;
    fp_frac_t  payload;
    srt_opnd_t srt;
  } opnd_class_t;

  typedef struct packed {
    logic     result_zero;
    logic     result_inf;
    logic     result_qnan;
    logic     result_sign;
    logic     nv;
    logic     dz;
    logic     srt_skip;
    logic     of_rm_lfn;
    logic     qnan_sign;
    fp_frac_t qnan_f;
    fp_rm_t   rm;
  } special_rslt_t;

  typedef struct packed {
    special_rslt_t special;
    logic          op0_norm;
    logic          op1_norm;
    fp_expnt_t     expnt_add0;
    fp_expnt_t     expnt_add1;
    logic          op_sqrt;
    fp_fmt_t       fmt;
  } vfdsu_ex2_t;

endpackage

`default_nettype wire

// ==== logic/vfdsu_prepare.sv ====
/*
 * ex1 operand prepare top: two operand unpackers, special detect,
 * srt prepare and the ex2 pipe register
 */
`default_nettype none

module vfdsu_prepare
  import vfdsu_pkg::*;
(
  input  logic       ex1_pipe_clk,
  input  logic       cpurst_b,
  input  vfdsu_req_t ex1_req,
  input  logic       ex1_pipedown,
  input  fp_rm_t     ex1_static_rm,
  input  fp_rm_t     dyn_rm,
  input  logic       dqnan_en,
  output srt_rem_t   ex1_remainder,
  output srt_opnd_t  ex1_divisor,
  output vfdsu_ex2_t ex2
);

  opnd_class_t   op0_cls;
  opnd_class_t   op1_cls;
  special_rslt_t special;
  fp_expnt_t     expnt_add0;
  fp_expnt_t     expnt_add1;
  vfdsu_ex2_t    ex2_nxt;

  vfdsu_operand_unpack u_op0_unpack (
    .src (ex1_req.src0),
    .fmt (ex1_req.fmt),
    .cls (op0_cls)
  );

  vfdsu_operand_unpack u_op1_unpack (
    .src (ex1_req.src1),
    .fmt (ex1_req.fmt),
    .cls (op1_cls)
  );

  vfdsu_special_detect u_special_detect (
    .op0_cls   (op0_cls),
    .op1_cls   (op1_cls),
    .op_sqrt   (ex1_req.op_sqrt),
    .static_rm (ex1_static_rm),
    .dyn_rm    (dyn_rm),
    .dqnan_en  (dqnan_en),
    .rslt      (special)
  );

  // remainder and divisor leave in ex1
  vfdsu_srt_prepare u_srt_prepare (
    .op0_cls    (op0_cls),
    .op1_cls    (op1_cls),
    .op_sqrt    (ex1_req.op_sqrt),
    .fmt        (ex1_req.fmt),
    .remainder  (ex1_remainder),
    .divisor    (ex1_divisor),
    .expnt_add0 (expnt_add0),
    .expnt_add1 (expnt_add1)
  );

  always_comb
  begin
    ex2_nxt.special    = special;
    ex2_nxt.op0_norm   = op0_cls.norm;
    ex2_nxt.op1_norm   = op1_cls.norm;
    ex2_nxt.expnt_add0 = expnt_add0;
    ex2_nxt.expnt_add1 = expnt_add1;
    ex2_nxt.op_sqrt    = ex1_req.op_sqrt;
    ex2_nxt.fmt        = ex1_req.fmt;
  end

  // loads on pipedown, holds otherwise
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex2 <= '0;
    end
    else if (ex1_pipedown)
    begin
      ex2 <= ex2_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vfdsu_special_detect.sv ====
/*
 * special case detect: nv/dz flags, zero/inf/qnan results,
 * nan payload and sign select, rounding-mode resolve, lfn on overflow
 */
`default_nettype none

`include "vfdsu_macros.svh"

module vfdsu_special_detect
  import vfdsu_pkg::*;
(
  input  opnd_class_t   op0_cls,
  input  opnd_class_t   op1_cls,
  input  logic          op_sqrt,
  input  fp_rm_t        static_rm,
  input  fp_rm_t        dyn_rm,
  input  logic          dqnan_en,
  output special_rslt_t rslt
);

  logic   op0_nan;
  logic   op1_nan;
  logic   div_nv;
  logic   sqrt_nv;
  logic   nv;
  logic   dz;
  logic   rst_zero;
  logic   rst_inf;
  logic   rst_qnan;
  logic   rst_sign;
  logic   default_nan;
  logic   op1_snan_sel;
  logic   op1_qnan_sel;
  fp_rm_t rm;
  logic   of_rm_lfn;

  assign op0_nan = op0_cls.snan | op0_cls.qnan;
  assign op1_nan = op1_cls.snan | op1_cls.qnan;

  // invalid
  assign div_nv  = op0_cls.snan | op1_cls.snan
                 | (op0_cls.zero & op1_cls.zero)
                 | (op0_cls.inf & op1_cls.inf);
  assign sqrt_nv = op0_cls.snan
                 | (op0_cls.sign & (op0_cls.norm | op0_cls.inf));
  assign nv      = op_sqrt ? sqrt_nv : div_nv;

  // divide by zero, divide only
  assign dz = ~op_sqrt & op0_cls.norm & op1_cls.zero;

  assign rst_zero = op_sqrt ? op0_cls.zero
                            : (op0_cls.zero & op1_cls.norm)
                            | (~op0_nan & ~op0_cls.inf & op1_cls.inf);
  assign rst_inf  = op_sqrt ? (op0_cls.inf & ~op0_cls.sign)
                            : (op0_cls.inf & ~op1_nan & ~op1_cls.inf) | dz;
  assign rst_qnan = op_sqrt ? (op0_cls.qnan | nv)
                            : (op0_cls.qnan | op1_cls.qnan | nv);
  assign rst_sign = ~op_sqrt & (op0_cls.sign ^ op1_cls.sign);

  // 0/0, inf/inf and negative sqrt always give the default nan
  assign default_nan = op_sqrt ? (op0_cls.sign & (op0_cls.norm | op0_cls.inf))
                               : (op0_cls.zero & op1_cls.zero)
                               | (op0_cls.inf & op1_cls.inf);

  assign op1_snan_sel = op1_cls.snan & ~op_sqrt;
  assign op1_qnan_sel = op1_cls.qnan & ~op_sqrt;

  assign rm = (static_rm == `VFDSU_RM_DYN) ? dyn_rm : static_rm;

  // overflow goes to the largest finite number instead of inf
  always_comb
  begin
    case (rm)
      `VFDSU_RM_RTZ: of_rm_lfn = 1'b1;
      `VFDSU_RM_RDN: of_rm_lfn = ~rst_sign;
      `VFDSU_RM_RUP: of_rm_lfn = rst_sign;
      default:       of_rm_lfn = 1'b0;
    endcase
  end

  always_comb
  begin
    rslt.result_zero = rst_zero;
    rslt.result_inf  = rst_inf;
    rslt.result_qnan = rst_qnan;
    rslt.result_sign = rst_sign;
    rslt.nv          = nv;
    rslt.dz          = dz;
    rslt.srt_skip    = rst_zero | rst_inf | rst_qnan;
    rslt.of_rm_lfn   = of_rm_lfn;
    rslt.rm          = rm;
    // nan select, snan before qnan, op0 before op1
    if (default_nan)
    begin
      rslt.qnan_f    = {1'b1, {(`VFDSU_FRAC_W-1){1'b0}}};
      rslt.qnan_sign = 1'b0;
    end
    else if (dqnan_en && op0_cls.snan)
    begin
      rslt.qnan_f    = op0_cls.payload;
      rslt.qnan_sign = op0_cls.sign;
    end
    else if (dqnan_en && op1_snan_sel)
    begin
      rslt.qnan_f    = op1_cls.payload;
      rslt.qnan_sign = op1_cls.sign;
    end
    else if (dqnan_en && op0_cls.qnan)
    begin
      rslt.qnan_f    = op0_cls.payload;
      rslt.qnan_sign = op0_cls.sign;
    end
    else if (dqnan_en && op1_qnan_sel)
    begin
      rslt.qnan_f    = op1_cls.payload;
      rslt.qnan_sign = op1_cls.sign;
    end
    else
    begin
      rslt.qnan_f    = {1'b1, {(`VFDSU_FRAC_W-1){1'b0}}};
      rslt.qnan_sign = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vfdsu_srt_prepare.sv ====
/*
 * srt operand prepare: exponent adder operands, sqrt parity,
 * remainder and divisor alignment
 */
`default_nettype none

`include "vfdsu_macros.svh"

module vfdsu_srt_prepare
  import vfdsu_pkg::*;
(
  input  opnd_class_t op0_cls,
  input  opnd_class_t op1_cls,
  input  logic        op_sqrt,
  input  fp_fmt_t     fmt,
  output srt_rem_t    remainder,
  output srt_opnd_t   divisor,
  output fp_expnt_t   expnt_add0,
  output fp_expnt_t   expnt_add1
);

  fp_expnt_t bias;
  logic      expnt_odd;

  always_comb
  begin
    case (fmt)
      `VFDSU_FMT_DOUBLE: bias = `VFDSU_BIAS_DOUBLE;
      `VFDSU_FMT_SINGLE: bias = `VFDSU_BIAS_SINGLE;
      default:           bias = `VFDSU_BIAS_HALF;
    endcase
  end

  assign expnt_add0 = op0_cls.expnt;
  // sqrt subtracts the bias downstream
  assign expnt_add1 = op_sqrt ? bias : op1_cls.expnt;

  // odd exponent difference keeps the sqrt radicand one place higher
  assign expnt_odd = expnt_add0[0] ^ expnt_add1[0];

  // divisor in [1/2, 1)
  assign divisor = op1_cls.srt;

  // div remainder in [1/8, 1/4), sqrt in [1/16, 1/4)
  assign remainder = (~op_sqrt | expnt_odd) ? {5'b0, op0_cls.srt, 2'b0}
                                            : {6'b0, op0_cls.srt, 1'b0};

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/bash
# build and run the prepare stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f vfdsu_prepare.f \
  --top-module tb_vfdsu_prepare -o vsim \
  && ./obj_dir/vsim > sim.log 2>&1 \
  || echo "build or run error" >> sim.log

cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

// ==== sim/tb_vfdsu_prepare.sv ====
/*
 * testbench top: clock, reset, stimulus table with random tail,
 * dut0 and the checker
 */
`default_nettype none

`include "vfdsu_macros.svh"

module tb_vfdsu_prepare
  import vfdsu_pkg::*;
;

  typedef struct packed {
    vfdsu_req_t req;
    fp_rm_t     srm;
    fp_rm_t     drm;
    logic       dq;
    logic       pd;
    logic       chk;
    logic [4:0] flags;
  } entry_t;

  logic        ex1_pipe_clk;
  logic        cpurst_b;
  vfdsu_req_t  ex1_req;
  logic        ex1_pipedown;
  fp_rm_t      ex1_static_rm;
  fp_rm_t      dyn_rm;
  logic        dqnan_en;
  srt_rem_t    ex1_remainder;
  srt_opnd_t   ex1_divisor;
  vfdsu_ex2_t  ex2;
  logic        tbl_valid;
  logic [4:0]  tbl_flags;
  int          chk_errors;
  int          chk_count;
  logic        rst_done;
  entry_t      table_q[$];
  logic [31:0] lfsr;
  int          tb_errors;

  vfdsu_prepare dut0 (
    .ex1_pipe_clk  (ex1_pipe_clk),
    .cpurst_b      (cpurst_b),
    .ex1_req       (ex1_req),
    .ex1_pipedown  (ex1_pipedown),
    .ex1_static_rm (ex1_static_rm),
    .dyn_rm        (dyn_rm),
    .dqnan_en      (dqnan_en),
    .ex1_remainder (ex1_remainder),
    .ex1_divisor   (ex1_divisor),
    .ex2           (ex2)
  );

  vfdsu_checker u_checker (
    .ex1_pipe_clk  (ex1_pipe_clk),
    .cpurst_b      (cpurst_b),
    .ex1_req       (ex1_req),
    .ex1_pipedown  (ex1_pipedown),
    .ex1_static_rm (ex1_static_rm),
    .dyn_rm        (dyn_rm),
    .dqnan_en      (dqnan_en),
    .ex1_remainder (ex1_remainder),
    .ex1_divisor   (ex1_divisor),
    .ex2           (ex2),
    .tbl_valid     (tbl_valid),
    .tbl_flags     (tbl_flags),
    .errors        (chk_errors),
    .checks        (chk_count),
    .rst_done      (rst_done)
  );

  initial
  begin
    ex1_pipe_clk = 1'b0;
    forever #10 ex1_pipe_clk = ~ex1_pipe_clk;
  end

  // galois step with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_entry(logic sq, fp_fmt_t f, fp_src_t s0, fp_src_t s1, fp_rm_t srm,
                           fp_rm_t drm, logic dq, logic pd, logic [4:0] flags);
    entry_t e;
    e.req = '{op_sqrt: sq, fmt: f, src0: s0, src1: s1};
    e.srm = srm;
    e.drm = drm;
    e.dq = dq;
    e.pd = pd;
    e.chk = 1'b1;
    e.flags = flags;
    table_q.push_back(e);
  endtask

  task automatic wait_check();
    int prev;
    int n;
    prev = chk_count;
    n = 0;
    while (chk_count == prev && n < 60)
    begin
      #1;
      n++;
    end
    if (chk_count == prev)
    begin
      $display("timeout: checker did not sample the outputs");
      tb_errors++;
    end
  endtask

  task automatic apply(entry_t e);
    @(posedge ex1_pipe_clk);
    #2;
    ex1_req = e.req;
    ex1_static_rm = e.srm;
    dyn_rm = e.drm;
    dqnan_en = e.dq;
    ex1_pipedown = e.pd;
    tbl_valid = e.chk;
    tbl_flags = e.flags;
    wait_check();
  endtask

  task automatic build_table();
    // double format cases with flags in order nv dz zero inf qnan
    add_entry(0, 0, 64'h0, 64'h0, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 0, 64'h7ff0000000000000, 64'hfff0000000000000, 0, 0, 1, 1, 5'b10001);
    add_entry(0, 0, 64'h3ff0000000000000, 64'h0, 0, 0, 0, 1, 5'b01010);
    add_entry(0, 0, 64'h0, 64'h3ff0000000000000, 0, 0, 0, 1, 5'b00100);
    add_entry(0, 0, 64'hbff0000000000000, 64'h7ff0000000000000, 0, 0, 0, 1, 5'b00100);
    add_entry(0, 0, 64'h7ff0000000000000, 64'h0, 0, 0, 0, 1, 5'b00010);
    add_entry(0, 0, 64'hfff0000000000001, 64'h3ff0000000000000, 0, 0, 1, 1, 5'b10001);
    add_entry(0, 0, 64'h3ff0000000000000, 64'h7ff4000000000002, 0, 0, 1, 1, 5'b10001);
    add_entry(0, 0, 64'h7ff0000000000009, 64'h3ff0000000000000, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 0, 64'h7ff8000000000005, 64'hfff8000000000007, 0, 0, 1, 1, 5'b00001);
    add_entry(0, 0, 64'h7ff8000000000005, 64'h3ff0000000000000, 0, 0, 0, 1, 5'b00001);
    add_entry(1, 0, 64'hbff0000000000000, 64'h0, 0, 0, 1, 1, 5'b10001);
    add_entry(1, 0, 64'h7ff0000000000000, 64'h0, 0, 0, 0, 1, 5'b00010);
    add_entry(1, 0, 64'h8000000000000000, 64'h0, 0, 0, 0, 1, 5'b00100);
    add_entry(1, 0, 64'hfff8000000000003, 64'h7ff0000000000001, 0, 0, 1, 1, 5'b00001);
    // single
    add_entry(0, 1, 64'h0, 64'h80000000, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 1, 64'h7f800000, 64'hff800000, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 1, 64'hbf800000, 64'h0, 0, 0, 0, 1, 5'b01010);
    add_entry(0, 1, 64'h7fc00003, 64'hff800001, 0, 0, 1, 1, 5'b10001);
    add_entry(0, 1, 64'h7f800005, 64'h7fc00001, 0, 0, 0, 1, 5'b10001);
    add_entry(1, 1, 64'hc0800000, 64'h0, 0, 0, 0, 1, 5'b10001);
    add_entry(1, 1, 64'h7f800000, 64'h0, 0, 0, 0, 1, 5'b00010);
    add_entry(1, 1, 64'hffc00002, 64'h0, 0, 0, 0, 1, 5'b00001);
    add_entry(0, 1, 64'hffc00009, 64'h3f800000, 0, 0, 1, 1, 5'b00001);
    // half
    add_entry(0, 2, 64'h8000, 64'h0, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 2, 64'h7c00, 64'hfc00, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 2, 64'h3c00, 64'h8000, 0, 0, 0, 1, 5'b01010);
    add_entry(1, 2, 64'hbc00, 64'h0, 0, 0, 0, 1, 5'b10001);
    add_entry(1, 2, 64'h7c00, 64'h0, 0, 0, 0, 1, 5'b00010);
    add_entry(0, 2, 64'h3c00, 64'hfe02, 0, 0, 1, 1, 5'b00001);
    add_entry(0, 2, 64'h7e04, 64'h3c00, 0, 0, 0, 1, 5'b00001);
    add_entry(0, 2, 64'h7c01, 64'h3c00, 0, 0, 0, 1, 5'b10001);
    add_entry(0, 2, 64'h3c00, 64'hfd01, 0, 0, 1, 1, 5'b10001);
    // normal and subnormal operands over both sqrt parities
    add_entry(0, 0, 64'h4008000000000000, 64'h4000000000000000, 0, 0, 0, 1, 5'b0);
    add_entry(1, 0, 64'h4000000000000000, 64'h0, 0, 0, 0, 1, 5'b0);
    add_entry(1, 0, 64'h3ff0000000000000, 64'h0, 0, 0, 0, 1, 5'b0);
    add_entry(0, 0, 64'h0000000000000003, 64'h3ff0000000000000, 0, 0, 0, 1, 5'b0);
    add_entry(1, 1, 64'h00000005, 64'h0, 0, 0, 0, 1, 5'b0);
    add_entry(1, 1, 64'h00400000, 64'h0, 0, 0, 0, 1, 5'b0);
    add_entry(0, 2, 64'h0001, 64'h0003, 0, 0, 0, 1, 5'b0);
    add_entry(1, 2, 64'h0001, 64'h0, 0, 0, 0, 1, 5'b0);
    // rounding modes for both result signs
    add_entry(0, 0, 64'hbff0000000000000, 64'h3ff0000000000000, 7, 2, 0, 1, 5'b0);
    add_entry(0, 0, 64'h3ff0000000000000, 64'h3ff0000000000000, 7, 2, 0, 1, 5'b0);
    add_entry(0, 1, 64'hbf800000, 64'h3f800000, 3, 0, 0, 1, 5'b0);
    add_entry(0, 1, 64'h3f800000, 64'h3f800000, 7, 3, 0, 1, 5'b0);
    add_entry(0, 2, 64'hbc00, 64'h3c00, 1, 2, 0, 1, 5'b0);
    add_entry(0, 2, 64'h3c00, 64'h3c00, 7, 1, 0, 1, 5'b0);
    add_entry(0, 2, 64'h3c00, 64'hbc00, 4, 1, 0, 1, 5'b0);
    add_entry(0, 0, 64'h3ff0000000000000, 64'h3ff0000000000000, 4, 0, 0, 1, 5'b0);
    // ex2 holds the last load without a strobe
    add_entry(0, 0, 64'h0, 64'h0, 0, 0, 0, 0, 5'b0);
    add_entry(1, 2, 64'hbc00, 64'h0, 7, 3, 1, 0, 5'b0);
    add_entry(0, 1, 64'h3f800000, 64'h0, 0, 0, 0, 1, 5'b01010);
  endtask

  task automatic add_random(int count);
    entry_t      e;
    logic [63:0] v;
    for (int i = 0; i < count; i++)
    begin
      take_bits(1, v);
      e.req.op_sqrt = v[0];
      take_bits(2, v);
      e.req.fmt = (v[1:0] == 2'd3) ? `VFDSU_FMT_HALF : v[1:0];
      take_bits(64, v);
      e.req.src0 = v;
      take_bits(64, v);
      e.req.src1 = v;
      take_bits(3, v);
      e.srm = v[2:0];
      take_bits(3, v);
      e.drm = v[2:0];
      take_bits(2, v);
      e.dq = v[0];
      e.pd = v[1];
      e.chk = 1'b0;
      e.flags = '0;
      table_q.push_back(e);
    end
  endtask

  initial
  begin
    int n;
    int total;
    cpurst_b = 1'b0;
    ex1_req = '0;
    ex1_pipedown = 1'b0;
    ex1_static_rm = '0;
    dyn_rm = '0;
    dqnan_en = 1'b0;
    tbl_valid = 1'b0;
    tbl_flags = '0;
    tb_errors = 0;
    lfsr = 32'h3e08;
    build_table();
    add_random(40);
    for (int i = 0; i < 5; i++)
      @(posedge ex1_pipe_clk);
    #2;
    cpurst_b = 1'b1;
    n = 0;
    while (!rst_done && n < 100)
    begin
      #1;
      n++;
    end
    if (!rst_done)
    begin
      $display("timeout: reset release never seen");
      tb_errors++;
    end
    foreach (table_q[i])
      apply(table_q[i]);
    // one more edge so the last load gets compared
    apply('0);
    total = chk_errors + tb_errors;
    $display("errors: %0d", total);
    if (total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/vfdsu_checker.sv ====
/*
 * reference model of the prepare stage and the comparison of the
 * ex1 srt outputs and the ex2 register against it
 */
`default_nettype none

`include "vfdsu_macros.svh"

module vfdsu_checker
  import vfdsu_pkg::*;
(
  input  logic       ex1_pipe_clk,
  input  logic       cpurst_b,
  input  vfdsu_req_t ex1_req,
  input  logic       ex1_pipedown,
  input  fp_rm_t     ex1_static_rm,
  input  fp_rm_t     dyn_rm,
  input  logic       dqnan_en,
  input  srt_rem_t   ex1_remainder,
  input  srt_opnd_t  ex1_divisor,
  input  vfdsu_ex2_t ex2,
  input  logic       tbl_valid,
  input  logic [4:0] tbl_flags,
  output int         errors,
  output int         checks,
  output logic       rst_done
);

  opnd_class_t c0;
  opnd_class_t c1;
  vfdsu_ex2_t  m_ex2;
  vfdsu_ex2_t  exp_ex2;
  srt_rem_t    m_rem;
  logic        tbl_hold_valid;
  logic [4:0]  tbl_hold;

  // class of one operand, field sizes taken per format
  function automatic opnd_class_t classify(fp_src_t s, fp_fmt_t f);
    opnd_class_t c;
    int          ew;
    int          fw;
    int          e;
    int          emax;
    int          l;
    logic [63:0] t;
    logic [51:0] fr;
    ew = (f == `VFDSU_FMT_DOUBLE) ? 11 : (f == `VFDSU_FMT_SINGLE) ? 8 : 5;
    fw = (f == `VFDSU_FMT_DOUBLE) ? 52 : (f == `VFDSU_FMT_SINGLE) ? 23 : 10;
    emax = (1 << ew) - 1;
    c = '0;
    c.sign = s[ew + fw];
    t = s >> fw;
    e = int'(t[10:0]) & emax;
    t = s << (64 - fw);
    fr = t[63:12];
    c.zero = (e == 0) && (fr == '0);
    c.inf = (e == emax) && (fr == '0);
    c.snan = (e == emax) && (fr != '0) && !fr[51];
    c.qnan = (e == emax) && fr[51];
    c.denorm = (e == 0) && (fr != '0);
    c.norm = ((e != 0) && (e != emax)) || c.denorm;
    c.payload = fr;
    if (c.denorm)
    begin
      l = 0;
      while (!fr[51])
      begin
        fr = fr << 1;
        l++;
      end
      c.expnt = fp_expnt_t'(-l);
      c.srt = {fr, 1'b0};
    end
    else
    begin
      c.expnt = fp_expnt_t'(e);
      c.srt = {1'b1, c.payload};
    end
    return c;
  endfunction

  function automatic special_rslt_t special_model(opnd_class_t a, opnd_class_t b,
                                                  logic sq, fp_rm_t srm, fp_rm_t drm,
                                                  logic dq);
    special_rslt_t r;
    logic          b_snan;
    logic          b_qnan;
    logic          inv;
    r = '0;
    b_snan = !sq && b.snan;
    b_qnan = !sq && b.qnan;
    if (sq)
    begin
      r.nv = a.snan || (a.sign && (a.norm || a.inf));
      r.result_zero = a.zero;
      r.result_inf = a.inf && !a.sign;
    end
    else
    begin
      r.nv = a.snan || b.snan || (a.zero && b.zero) || (a.inf && b.inf);
      r.dz = a.norm && b.zero;
      r.result_zero = (a.zero && b.norm) || (!a.snan && !a.qnan && !a.inf && b.inf);
      r.result_inf = (a.inf && !b.snan && !b.qnan && !b.inf) || r.dz;
      r.result_sign = a.sign ^ b.sign;
    end
    r.result_qnan = a.qnan || b_qnan || r.nv;
    r.srt_skip = r.result_zero || r.result_inf || r.result_qnan;
    r.rm = (srm == `VFDSU_RM_DYN) ? drm : srm;
    case (r.rm)
      `VFDSU_RM_RTZ: r.of_rm_lfn = 1'b1;
      `VFDSU_RM_RDN: r.of_rm_lfn = !r.result_sign;
      `VFDSU_RM_RUP: r.of_rm_lfn = r.result_sign;
      default:       r.of_rm_lfn = 1'b0;
    endcase
    // invalid without a signalling operand takes the default nan
    inv = r.nv && !a.snan && !b_snan;
    r.qnan_f = 52'h8000000000000;
    if (!inv && dq)
    begin
      if (a.snan)
        {r.qnan_sign, r.qnan_f} = {a.sign, a.payload};
      else if (b_snan)
        {r.qnan_sign, r.qnan_f} = {b.sign, b.payload};
      else if (a.qnan)
        {r.qnan_sign, r.qnan_f} = {a.sign, a.payload};
      else if (b_qnan)
        {r.qnan_sign, r.qnan_f} = {b.sign, b.payload};
    end
    return r;
  endfunction

  always_comb
  begin
    c0 = classify(ex1_req.src0, ex1_req.fmt);
    c1 = classify(ex1_req.src1, ex1_req.fmt);
    m_ex2.special = special_model(c0, c1, ex1_req.op_sqrt, ex1_static_rm, dyn_rm, dqnan_en);
    m_ex2.op0_norm = c0.norm;
    m_ex2.op1_norm = c1.norm;
    m_ex2.expnt_add0 = c0.expnt;
    m_ex2.expnt_add1 = c1.expnt;
    if (ex1_req.op_sqrt)
    begin
      case (ex1_req.fmt)
        `VFDSU_FMT_DOUBLE: m_ex2.expnt_add1 = `VFDSU_BIAS_DOUBLE;
        `VFDSU_FMT_SINGLE: m_ex2.expnt_add1 = `VFDSU_BIAS_SINGLE;
        default:           m_ex2.expnt_add1 = `VFDSU_BIAS_HALF;
      endcase
    end
    m_ex2.op_sqrt = ex1_req.op_sqrt;
    m_ex2.fmt = ex1_req.fmt;
    m_rem = {5'b0, c0.srt, 2'b0};
    // even parity sqrt radicand sits one place lower
    if (ex1_req.op_sqrt && !(m_ex2.expnt_add0[0] ^ m_ex2.expnt_add1[0]))
      m_rem = m_rem >> 1;
  end

  task automatic check_val(string name, logic [63:0] exp_v, logic [63:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("MISMATCH t=%0t %s exp=%h act=%h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      exp_ex2 <= '0;
      tbl_hold_valid <= 1'b0;
      tbl_hold <= '0;
      rst_done <= 1'b0;
    end
    else
    begin
      rst_done <= 1'b1;
      if (ex1_pipedown)
      begin
        exp_ex2 <= m_ex2;
        tbl_hold_valid <= tbl_valid;
        tbl_hold <= tbl_flags;
      end
    end
  end

  initial
  begin
    errors = 0;
    checks = 0;
  end

  // mid-cycle, inputs and ex2 both settled
  always @(negedge ex1_pipe_clk)
  begin
    check_val("ex1_remainder", 64'(m_rem), 64'(ex1_remainder));
    check_val("ex1_divisor", 64'(c1.srt), 64'(ex1_divisor));
    check_val("ex2.special.result_zero", 64'(exp_ex2.special.result_zero),
              64'(ex2.special.result_zero));
    check_val("ex2.special.result_inf", 64'(exp_ex2.special.result_inf),
              64'(ex2.special.result_inf));
    check_val("ex2.special.result_qnan", 64'(exp_ex2.special.result_qnan),
              64'(ex2.special.result_qnan));
    check_val("ex2.special.result_sign", 64'(exp_ex2.special.result_sign),
              64'(ex2.special.result_sign));
    check_val("ex2.special.nv", 64'(exp_ex2.special.nv), 64'(ex2.special.nv));
    check_val("ex2.special.dz", 64'(exp_ex2.special.dz), 64'(ex2.special.dz));
    check_val("ex2.special.srt_skip", 64'(exp_ex2.special.srt_skip),
              64'(ex2.special.srt_skip));
    check_val("ex2.special.of_rm_lfn", 64'(exp_ex2.special.of_rm_lfn),
              64'(ex2.special.of_rm_lfn));
    check_val("ex2.special.qnan_sign", 64'(exp_ex2.special.qnan_sign),
              64'(ex2.special.qnan_sign));
    check_val("ex2.special.qnan_f", 64'(exp_ex2.special.qnan_f), 64'(ex2.special.qnan_f));
    check_val("ex2.special.rm", 64'(exp_ex2.special.rm), 64'(ex2.special.rm));
    check_val("ex2.op0_norm", 64'(exp_ex2.op0_norm), 64'(ex2.op0_norm));
    check_val("ex2.op1_norm", 64'(exp_ex2.op1_norm), 64'(ex2.op1_norm));
    check_val("ex2.expnt_add0", 64'(exp_ex2.expnt_add0), 64'(ex2.expnt_add0));
    check_val("ex2.expnt_add1", 64'(exp_ex2.expnt_add1), 64'(ex2.expnt_add1));
    check_val("ex2.op_sqrt", 64'(exp_ex2.op_sqrt), 64'(ex2.op_sqrt));
    check_val("ex2.fmt", 64'(exp_ex2.fmt), 64'(ex2.fmt));
    // hand-written flags of the table, order nv dz zero inf qnan
    if (tbl_hold_valid)
      check_val("ex2 table flags", 64'(tbl_hold),
                64'({ex2.special.nv, ex2.special.dz, ex2.special.result_zero,
                     ex2.special.result_inf, ex2.special.result_qnan}));
    checks++;
  end

endmodule

`default_nettype wire

// ==== vfdsu_prepare.f ====
+incdir+include
logic/vfdsu_pkg.sv
logic/vfdsu_operand_unpack.sv
logic/vfdsu_special_detect.sv
logic/vfdsu_srt_prepare.sv
logic/vfdsu_prepare.sv
sim/vfdsu_checker.sv
sim/tb_vfdsu_prepare.sv
